//--- vector_lane.f
verilog/lane_pkg.sv
verilog/lane_issue_pipe.sv
verilog/lane_vrf.sv
verilog/lane_read_format.sv
verilog/lane_result_route.sv
verilog/vector_lane.sv
test/vector_lane_tb.sv

//--- Makefile
# Verilator build and run for the vector lane testbench

VERILATOR ?= verilator
TOP       ?= vector_lane_tb
FILELIST  ?= vector_lane.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/vector_lane_tb.sv
`timescale 1ns/10ps

module vector_lane_tb
   import lane_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_TESTS    = 6;
   localparam int WATCHDOG_NS  = NUM_TESTS * 200 * CLK_PERIOD;
   localparam int MAX_BURST    = 16;

   ////////////////////////////////////////
   // DUT signals
   ////////////////////////////////////////

   logic                                 clk_i;
   logic                                 rstn_i;
   rd_req_t    [R_PORTS-1:0]             rd_req_i;
   issue_t     [W_PORTS-1:0]             issue_i;
   store_ctl_t                           store_ctl_i;
   wr_req_t    [W_PORTS-1:0]             wr_req_i;
   logic       [W_PORTS-1:0]             alu_vld_i;
   logic       [W_PORTS-1:0]             request_control_i;
   logic       [W_PORTS-1:0][XLEN-1:0]   alu_res_i;
   logic       [XLEN-1:0]                load_data_i;
   logic       [XLEN-1:0]                slide_data_i;
   logic       [W_PORTS-1:0][XLEN-1:0]   vs1_o;
   logic       [W_PORTS-1:0][XLEN-1:0]   vs2_o;
   logic       [W_PORTS-1:0][XLEN-1:0]   vs3_o;
   logic       [W_PORTS-1:0][ALU_CTRL_W-1:0] alu_opmode_o;
   logic       [W_PORTS-1:0]             alu_reduction_o;
   sew_t       [W_PORTS-1:0]             alu_read_sew_o;
   sew_t       [W_PORTS-1:0]             alu_write_sew_o;
   logic       [W_PORTS-1:0]             alu_vld_o;
   logic       [XLEN-1:0]                store_data_o;
   logic       [XLEN-1:0]                store_load_index_o;
   logic       [W_PORTS-1:0]             store_data_valid_o;
   logic       [W_PORTS-1:0]             store_load_index_valid_o;
   logic       [XLEN-1:0]                slide_data_o;

   // Mirror of the VRF contents
   logic [XLEN-1:0] model [VRF_DEPTH];
   logic [31:0]     lcg_state;

   // Issues of one burst and what each one should produce
   rd_req_t    [R_PORTS-1:0]           b_rq  [MAX_BURST];
   issue_t     [W_PORTS-1:0]           b_is  [MAX_BURST];
   store_ctl_t                         b_sc  [MAX_BURST];
   logic       [R_PORTS-1:0][XLEN-1:0] b_exp [MAX_BURST];
   logic       [XLEN-1:0]              b_raw [MAX_BURST];

   vector_lane u_dut (.*);

   ////////////////////////////////////////
   // Clock and watchdog
   ////////////////////////////////////////

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   initial begin
      #(WATCHDOG_NS);
      report_error("timeout: DUT did not finish");
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [VRF_AW-1:0] rand_addr();
      logic [31:0] r;
      r = next_rand();
      return r[VRF_AW+7:8];
   endfunction

   // Zero-extended element of a word
   function automatic logic [XLEN-1:0] elem_of(logic [XLEN-1:0] word, sew_t sew,
                                                logic [1:0] bsel);
      logic [XLEN-1:0] sh;
      if (sew == SEW_8) begin
         sh = word >> (8 * int'(bsel));
         return {24'd0, sh[7:0]};
      end else if (sew == SEW_16) begin
         // Only bit 0 picks the half
         sh = word >> (16 * int'(bsel[0]));
         return {16'd0, sh[15:0]};
      end
      return word;
   endfunction

   function automatic issue_t make_issue(logic [ALU_CTRL_W-1:0] ctrl, logic red, sew_t rs,
                                         sew_t ws, rport_sel_t op3, logic [2:0] vld);
      issue_t is;
      is.alu_ctrl    = ctrl;
      is.reduction   = red;
      is.read_sew    = rs;
      is.write_sew   = ws;
      is.op3_sel     = op3;
      is.read_valid  = vld[0];
      is.store_valid = vld[1];
      is.index_valid = vld[2];
      return is;
   endfunction

   task automatic report_error(string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(string name, logic [XLEN-1:0] got, logic [XLEN-1:0] exp);
      if (got !== exp) begin
         report_error($sformatf("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp));
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         report_error($sformatf("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp));
      end
   endtask

   task automatic check_issue(string name, issue_t got, issue_t exp);
      issue_t g;
      issue_t e;
      g = got;
      e = exp;
      // op3_sel only shows through vs3
      g.op3_sel = '0;
      e.op3_sel = '0;
      if (g !== e) begin
         report_error($sformatf("[FAIL] %0t ns %s got %h expected %h", $time, name, g, e));
      end
   endtask

   // Inputs change 1 ns after the rising edge
   task automatic step();
      @(posedge clk_i);
      #1;
   endtask

   task automatic drive_idle();
      rd_req_i          = '0;
      issue_i           = '0;
      store_ctl_i       = '0;
      wr_req_i          = '0;
      alu_vld_i         = '0;
      request_control_i = '0;
      alu_res_i         = '0;
      load_data_i       = '0;
      slide_data_i      = '0;
   endtask

   ////////////////////////////////////////
   // Write and read sequences
   ////////////////////////////////////////

   // One write on one port mirrored in the model
   task automatic write_word(int port, logic [VRF_AW-1:0] addr, logic [3:0] bwen, wsrc_t src,
                             logic vld, logic reqc);
      logic [XLEN-1:0] data;
      alu_res_i[0]            = next_rand();
      alu_res_i[1]            = next_rand();
      load_data_i             = next_rand();
      slide_data_i            = next_rand();
      wr_req_i                = '0;
      wr_req_i[port].addr     = addr;
      wr_req_i[port].bwen     = bwen;
      wr_req_i[port].src      = src;
      alu_vld_i               = '0;
      alu_vld_i[port]         = vld;
      request_control_i       = '0;
      request_control_i[port] = reqc;
      case (src)
         WSRC_ALU:   data = alu_res_i[port];
         WSRC_LOAD:  data = load_data_i;
         WSRC_SLIDE: data = slide_data_i;
         default:    data = '0;
      endcase
      if ((|bwen) && (vld || reqc)) begin
         for (int b = 0; b < 4; b++) begin
            if (bwen[b]) begin
               model[addr][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
      step();
      wr_req_i          = '0;
      alu_vld_i         = '0;
      request_control_i = '0;
   endtask

   // Expected words taken from the model at issue time
   task automatic load_issue(int i);
      for (int p = 0; p < R_PORTS; p++) begin
         // Slot k owns ports 2k and 2k+1
         b_exp[i][p] = elem_of(model[b_rq[i][p].addr], b_is[i][p / 2].read_sew,
                               b_rq[i][p].byte_sel);
      end
      b_raw[i]    = model[b_rq[i][SLIDE_PORT].addr];
      rd_req_i    = b_rq[i];
      issue_i     = b_is[i];
      store_ctl_i = b_sc[i];
   endtask

   task automatic check_outputs(int i);
      issue_t got;
      for (int k = 0; k < W_PORTS; k++) begin
         check_word($sformatf("vs1_o[%0d]", k), vs1_o[k], b_exp[i][2*k]);
         check_word($sformatf("vs2_o[%0d]", k), vs2_o[k], b_exp[i][2*k + 1]);
         check_word($sformatf("vs3_o[%0d]", k), vs3_o[k], b_exp[i][b_is[i][k].op3_sel]);
         got             = '0;
         got.alu_ctrl    = alu_opmode_o[k];
         got.reduction   = alu_reduction_o[k];
         got.read_sew    = alu_read_sew_o[k];
         got.write_sew   = alu_write_sew_o[k];
         got.read_valid  = alu_vld_o[k];
         got.store_valid = store_data_valid_o[k];
         got.index_valid = store_load_index_valid_o[k];
         check_issue($sformatf("issue fields slot %0d", k), got, b_is[i][k]);
      end
      check_word("store_data_o", store_data_o, b_exp[i][b_sc[i].store_sel]);
      check_word("store_load_index_o", store_load_index_o, b_exp[i][b_sc[i].index_sel]);
   endtask

   // Back-to-back issues with slide one edge and operands two edges later
   task automatic run_burst(int n);
      for (int c = 0; c < n + 2; c++) begin
         if (c >= 1 && c <= n) begin
            check_word("slide_data_o", slide_data_o, b_raw[c-1]);
         end
         if (c >= 2) begin
            check_outputs(c - 2);
         end
         if (c < n) begin
            load_issue(c);
         end else begin
            rd_req_i    = '0;
            issue_i     = '0;
            store_ctl_i = '0;
         end
         step();
      end
      // Valids last one cycle per issue
      for (int k = 0; k < W_PORTS; k++) begin
         check_bit($sformatf("alu_vld_o[%0d]", k), alu_vld_o[k], 1'b0);
         check_bit($sformatf("store_data_valid_o[%0d]", k), store_data_valid_o[k], 1'b0);
         check_bit($sformatf("store_load_index_valid_o[%0d]", k),
                   store_load_index_valid_o[k], 1'b0);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////

   task automatic test_reset();
      for (int k = 0; k < W_PORTS; k++) begin
         b_is[0][k] = '0;
      end
      b_exp[0] = '0;
      b_sc[0]  = '0;
      check_outputs(0);
   endtask

   task automatic test_word_path();
      logic [31:0] r;
      // Fill every word on alternating ports
      for (int a = 0; a < VRF_DEPTH; a++) begin
         write_word(a % 2, VRF_AW'(a), 4'hf, WSRC_ALU, 1'b1, 1'b0);
      end
      for (int i = 0; i < VRF_DEPTH / R_PORTS; i++) begin
         r = next_rand();
         for (int p = 0; p < R_PORTS; p++) begin
            b_rq[0][p].addr     = VRF_AW'(R_PORTS * i + p);
            b_rq[0][p].byte_sel = r[2*p +: 2];
         end
         b_is[0][0] = make_issue(r[13:8], 1'b0, SEW_32, SEW_32, 2'd0, 3'b001);
         b_is[0][1] = make_issue(r[21:16], 1'b0, SEW_32, SEW_32, 2'd1, 3'b001);
         b_sc[0]    = '0;
         run_burst(1);
      end
   endtask

   task automatic test_sources();
      logic [VRF_AW-1:0] addrs [12];
      logic [31:0]       r;
      logic [3:0]        bwen;
      for (int i = 0; i < 12; i++) begin
         addrs[i] = rand_addr();
         r        = next_rand();
         bwen     = r[11:8];
         // Keep the enables partial
         if (bwen == 4'hf || bwen == 4'h0) begin
            bwen = 4'b0101;
         end
         write_word(i % 2, addrs[i], bwen, wsrc_t'(1 + i % 3), 1'b0, 1'b1);
      end
      // A write without a requester and one without byte enables
      write_word(0, addrs[0], 4'hf, WSRC_LOAD, 1'b0, 1'b0);
      write_word(1, addrs[1], 4'h0, WSRC_ALU, 1'b1, 1'b1);
      for (int i = 0; i < 3; i++) begin
         for (int p = 0; p < R_PORTS; p++) begin
            b_rq[0][p].addr     = addrs[R_PORTS * i + p];
            b_rq[0][p].byte_sel = 2'd0;
         end
         b_is[0][0] = make_issue(6'd1, 1'b0, SEW_32, SEW_32, 2'd2, 3'b001);
         b_is[0][1] = make_issue(6'd2, 1'b0, SEW_32, SEW_32, 2'd3, 3'b001);
         b_sc[0]    = '0;
         run_burst(1);
      end
   endtask

   task automatic test_format();
      sew_t sew;
      for (int i = 0; i < 8; i++) begin
         sew = (i < 4) ? SEW_8 : SEW_16;
         // Each port walks through every byte select
         for (int p = 0; p < R_PORTS; p++) begin
            b_rq[i][p].addr     = rand_addr();
            b_rq[i][p].byte_sel = 2'(i + p);
         end
         b_is[i][0] = make_issue(6'(i), 1'b0, sew, sew, 2'(i), 3'b001);
         b_is[i][1] = make_issue(6'(i + 8), 1'b1, sew, SEW_32, 2'(i + 1), 3'b001);
         b_sc[i]    = '0;
      end
      run_burst(8);
   endtask

   task automatic test_control();
      logic [31:0] r;
      for (int i = 0; i < 8; i++) begin
         r = next_rand();
         for (int p = 0; p < R_PORTS; p++) begin
            b_rq[i][p].addr     = rand_addr();
            b_rq[i][p].byte_sel = r[2*p +: 2];
         end
         b_is[i][0] = make_issue(r[13:8], r[14], r[16:15], r[18:17], r[20:19], r[23:21]);
         b_is[i][1] = make_issue(r[29:24], r[30], r[1:0], r[3:2], r[5:4], r[31:29]);
         b_sc[i]    = r[27:24];
      end
      run_burst(8);
   endtask

   task automatic test_store();
      logic [31:0] r;
      logic [3:0]  sel;
      for (int i = 0; i < MAX_BURST; i++) begin
         r   = next_rand();
         sel = 4'(i);
         for (int p = 0; p < R_PORTS; p++) begin
            b_rq[i][p].addr     = rand_addr();
            b_rq[i][p].byte_sel = r[2*p +: 2];
         end
         b_is[i][0] = make_issue(r[13:8], 1'b0, r[9:8], SEW_32, 2'd0, {sel[1:0], 1'b1});
         b_is[i][1] = make_issue(r[19:14], 1'b0, r[11:10], SEW_32, 2'd1, {sel[3:2], 1'b0});
         // Every pairing of store and index port
         b_sc[i]    = sel;
      end
      run_burst(MAX_BURST);
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      lcg_state = 32'h0f3f_bc34;
      rstn_i    = 1'b0;
      drive_idle();
      repeat (RESET_CYCLES) @(posedge clk_i);
      #1;
      rstn_i = 1'b1;
      test_reset();
      test_word_path();
      test_sources();
      test_format();
      test_control();
      test_store();
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- verilog/vector_lane.sv
`timescale 1ns/10ps

module vector_lane
   import lane_pkg::*;
(
   input  logic                                 clk_i,
   input  logic                                 rstn_i,
   // Read requests and issue packets
   input  rd_req_t    [R_PORTS-1:0]             rd_req_i,
   input  issue_t     [W_PORTS-1:0]             issue_i,
   input  store_ctl_t                           store_ctl_i,
   // Write requests and write data sources
   input  wr_req_t    [W_PORTS-1:0]             wr_req_i,
   input  logic       [W_PORTS-1:0]             alu_vld_i,
   input  logic       [W_PORTS-1:0]             request_control_i,
   input  logic       [W_PORTS-1:0][XLEN-1:0]   alu_res_i,
   input  logic       [XLEN-1:0]                load_data_i,
   input  logic       [XLEN-1:0]                slide_data_i,
   // ALU side
   output logic [W_PORTS-1:0][XLEN-1:0]         vs1_o,
   output logic [W_PORTS-1:0][XLEN-1:0]         vs2_o,
   output logic [W_PORTS-1:0][XLEN-1:0]         vs3_o,
   output logic [W_PORTS-1:0][ALU_CTRL_W-1:0]   alu_opmode_o,
   output logic [W_PORTS-1:0]                   alu_reduction_o,
   output sew_t [W_PORTS-1:0]                   alu_read_sew_o,
   output sew_t [W_PORTS-1:0]                   alu_write_sew_o,
   output logic [W_PORTS-1:0]                   alu_vld_o,
   // Load/store and slide side
   output logic [XLEN-1:0]                      store_data_o,
   output logic [XLEN-1:0]                      store_load_index_o,
   output logic [W_PORTS-1:0]                   store_data_valid_o,
   output logic [W_PORTS-1:0]                   store_load_index_valid_o,
   output logic [XLEN-1:0]                      slide_data_o
);

   ////////////////////////////////////////
   // Internal wires
   ////////////////////////////////////////

   logic       [R_PORTS-1:0][VRF_AW-1:0] raddr;
   logic       [R_PORTS-1:0][1:0]        byte_sel;
   logic       [R_PORTS-1:0][XLEN-1:0]   rdata;
   logic       [R_PORTS-1:0][XLEN-1:0]   fmt;
   sew_t       [R_PORTS-1:0]             fmt_sew;
   logic       [R_PORTS-1:0][1:0]        fmt_byte_sel;
   issue_t     [W_PORTS-1:0]             issue_s2;
   store_ctl_t                           store_ctl_s2;
   wr_req_t    [W_PORTS-1:0]             vrf_wr;
   logic       [W_PORTS-1:0][XLEN-1:0]   vrf_wdata;
   logic       [W_PORTS-1:0]             vrf_wen;

   // Split read requests into address and byte select
   always_comb begin
      for (int p = 0; p < R_PORTS; p++) begin
         raddr[p]    = rd_req_i[p].addr;
         byte_sel[p] = rd_req_i[p].byte_sel;
      end
   end

   ////////////////////////////////////////
   // Decode
   ////////////////////////////////////////

   lane_issue_pipe u_issue_pipe (
      .clk_i          (clk_i),
      .rstn_i         (rstn_i),
      .issue_i        (issue_i),
      .store_ctl_i    (store_ctl_i),
      .byte_sel_i     (byte_sel),
      .fmt_sew_o      (fmt_sew),
      .fmt_byte_sel_o (fmt_byte_sel),
      .issue_o        (issue_s2),
      .store_ctl_o    (store_ctl_s2)
   );

   ////////////////////////////////////////
   // Execute
   ////////////////////////////////////////

   lane_vrf u_vrf (
      .clk_i   (clk_i),
      .raddr_i (raddr),
      .rdata_o (rdata),
      .wr_i    (vrf_wr),
      .wdata_i (vrf_wdata),
      .wen_i   (vrf_wen)
   );

   lane_read_format u_read_format (
      .clk_i      (clk_i),
      .rstn_i     (rstn_i),
      .raw_i      (rdata),
      .sew_i      (fmt_sew),
      .byte_sel_i (fmt_byte_sel),
      .fmt_o      (fmt)
   );

   ////////////////////////////////////////
   // Result
   ////////////////////////////////////////

   lane_result_route u_result_route (
      .fmt_i                    (fmt),
      .raw_slide_i              (rdata[SLIDE_PORT]),
      .issue_i                  (issue_s2),
      .store_ctl_i              (store_ctl_s2),
      .wr_req_i                 (wr_req_i),
      .alu_vld_i                (alu_vld_i),
      .request_control_i        (request_control_i),
      .alu_res_i                (alu_res_i),
      .load_data_i              (load_data_i),
      .slide_data_i             (slide_data_i),
      .wr_o                     (vrf_wr),
      .wdata_o                  (vrf_wdata),
      .wen_o                    (vrf_wen),
      .vs1_o                    (vs1_o),
      .vs2_o                    (vs2_o),
      .vs3_o                    (vs3_o),
      .alu_opmode_o             (alu_opmode_o),
      .alu_reduction_o          (alu_reduction_o),
      .alu_read_sew_o           (alu_read_sew_o),
      .alu_write_sew_o          (alu_write_sew_o),
      .alu_vld_o                (alu_vld_o),
      .store_data_o             (store_data_o),
      .store_load_index_o       (store_load_index_o),
      .store_data_valid_o       (store_data_valid_o),
      .store_load_index_valid_o (store_load_index_valid_o),
      .slide_data_o             (slide_data_o)
   );

endmodule

//--- verilog/lane_result_route.sv
`timescale 1ns/10ps

module lane_result_route
   import lane_pkg::*;
(
   // Read side
   input  logic       [R_PORTS-1:0][XLEN-1:0]       fmt_i,
   input  logic       [XLEN-1:0]                    raw_slide_i,
   input  issue_t     [W_PORTS-1:0]                 issue_i,
   input  store_ctl_t                               store_ctl_i,
   // Write side
   input  wr_req_t    [W_PORTS-1:0]                 wr_req_i,
   input  logic       [W_PORTS-1:0]                 alu_vld_i,
   input  logic       [W_PORTS-1:0]                 request_control_i,
   input  logic       [W_PORTS-1:0][XLEN-1:0]       alu_res_i,
   input  logic       [XLEN-1:0]                    load_data_i,
   input  logic       [XLEN-1:0]                    slide_data_i,
   // VRF write ports
   output wr_req_t    [W_PORTS-1:0]                 wr_o,
   output logic       [W_PORTS-1:0][XLEN-1:0]       wdata_o,
   output logic       [W_PORTS-1:0]                 wen_o,
   // ALU operands and controls
   output logic       [W_PORTS-1:0][XLEN-1:0]       vs1_o,
   output logic       [W_PORTS-1:0][XLEN-1:0]       vs2_o,
   output logic       [W_PORTS-1:0][XLEN-1:0]       vs3_o,
   output logic       [W_PORTS-1:0][ALU_CTRL_W-1:0] alu_opmode_o,
   output logic       [W_PORTS-1:0]                 alu_reduction_o,
   output sew_t       [W_PORTS-1:0]                 alu_read_sew_o,
   output sew_t       [W_PORTS-1:0]                 alu_write_sew_o,
   output logic       [W_PORTS-1:0]                 alu_vld_o,
   // Load/store side
   output logic       [XLEN-1:0]                    store_data_o,
   output logic       [XLEN-1:0]                    store_load_index_o,
   output logic       [W_PORTS-1:0]                 store_data_valid_o,
   output logic       [W_PORTS-1:0]                 store_load_index_valid_o,
   output logic       [XLEN-1:0]                    slide_data_o
);

   ////////////////////////////////////////
   // Write path
   ////////////////////////////////////////

   always_comb begin
      for (int k = 0; k < W_PORTS; k++) begin
         // Data source per write port
         case (wr_req_i[k].src)
            WSRC_ALU:   wdata_o[k] = alu_res_i[k];
            WSRC_LOAD:  wdata_o[k] = load_data_i;
            WSRC_SLIDE: wdata_o[k] = slide_data_i;
            default:    wdata_o[k] = '0;
         endcase
         // Needs a byte enable and a requester
         wen_o[k] = (|wr_req_i[k].bwen) & (alu_vld_i[k] | request_control_i[k]);
      end
   end

   assign wr_o = wr_req_i;

   ////////////////////////////////////////
   // Operands and issue fields
   ////////////////////////////////////////

   always_comb begin
      for (int k = 0; k < W_PORTS; k++) begin
         // Fixed port pair per slot
         vs1_o[k]           = fmt_i[2*k];
         vs2_o[k]           = fmt_i[2*k + 1];
         // Third operand from any port
         vs3_o[k]           = fmt_i[issue_i[k].op3_sel];
         alu_opmode_o[k]    = issue_i[k].alu_ctrl;
         alu_reduction_o[k] = issue_i[k].reduction;
         alu_read_sew_o[k]  = issue_i[k].read_sew;
         alu_write_sew_o[k] = issue_i[k].write_sew;
         alu_vld_o[k]       = issue_i[k].read_valid;
         store_data_valid_o[k]       = issue_i[k].store_valid;
         store_load_index_valid_o[k] = issue_i[k].index_valid;
      end
   end

   ////////////////////////////////////////
   // Store and slide data
   ////////////////////////////////////////

   assign store_data_o       = fmt_i[store_ctl_i.store_sel];
   assign store_load_index_o = fmt_i[store_ctl_i.index_sel];
   // Raw word, one edge ahead of operands
   assign slide_data_o       = raw_slide_i;

endmodule

//--- verilog/lane_read_format.sv
`timescale 1ns/10ps

module lane_read_format
   import lane_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          rstn_i,
   // Raw VRF words
   input  logic [R_PORTS-1:0][XLEN-1:0]  raw_i,
   // Stage 1 element width and byte select
   input  sew_t [R_PORTS-1:0]            sew_i,
   input  logic [R_PORTS-1:0][1:0]       byte_sel_i,
   // Formatted, registered words
   output logic [R_PORTS-1:0][XLEN-1:0]  fmt_o
);

   ////////////////////////////////////////
   // Element extraction
   ////////////////////////////////////////

   logic [R_PORTS-1:0][XLEN-1:0] fmt_d;

   always_comb begin
      for (int p = 0; p < R_PORTS; p++) begin
         case (sew_i[p])
            // Byte at byte_sel, zero-extended
            SEW_8: begin
               fmt_d[p] = XLEN'(raw_i[p][byte_sel_i[p]*8 +: 8]);
            end
            // Low or high halfword from bit 0
            SEW_16: begin
               fmt_d[p] = XLEN'(raw_i[p][byte_sel_i[p][0]*16 +: 16]);
            end
            // SEW_32 and the spare code
            default: begin
               fmt_d[p] = raw_i[p];
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Output register
   ////////////////////////////////////////

   // Cleared so operands read zero out of reset
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         fmt_o <= '0;
      end else begin
         fmt_o <= fmt_d;
      end
   end

endmodule

//--- verilog/lane_vrf.sv
`timescale 1ns/10ps

module lane_vrf
   import lane_pkg::*;
(
   input  logic                             clk_i,
   // Read ports
   input  logic    [R_PORTS-1:0][VRF_AW-1:0] raddr_i,
   output logic    [R_PORTS-1:0][XLEN-1:0]   rdata_o,
   // Write ports
   input  wr_req_t [W_PORTS-1:0]            wr_i,
   input  logic    [W_PORTS-1:0][XLEN-1:0]   wdata_i,
   input  logic    [W_PORTS-1:0]            wen_i
);

   ////////////////////////////////////////
   // Storage
   ////////////////////////////////////////

   // Plain register array, one word per entry
   logic [XLEN-1:0] mem [VRF_DEPTH];

   ////////////////////////////////////////
   // Write ports
   ////////////////////////////////////////

   // Byte lanes written independently
   // Later ports overwrite earlier ones on a shared byte
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < W_PORTS; w++) begin
         if (wen_i[w]) begin
            for (int b = 0; b < XLEN / 8; b++) begin
               if (wr_i[w].bwen[b]) begin
                  mem[wr_i[w].addr][b*8 +: 8] <= wdata_i[w][b*8 +: 8];
               end
            end
         end
      end
   end

   ////////////////////////////////////////
   // Read ports
   ////////////////////////////////////////

   // Registered read, one edge of latency
   // Same-edge write is not forwarded, old word comes out
   always_ff @(posedge clk_i) begin
      for (int r = 0; r < R_PORTS; r++) begin
         rdata_o[r] <= mem[raddr_i[r]];
      end
   end

endmodule

//--- verilog/lane_issue_pipe.sv
`timescale 1ns/10ps

module lane_issue_pipe
   import lane_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rstn_i,
   // Issue side
   input  issue_t     [W_PORTS-1:0]     issue_i,
   input  store_ctl_t                   store_ctl_i,
   input  logic       [R_PORTS-1:0][1:0] byte_sel_i,
   // Toward the read formatter, stage 1
   output sew_t       [R_PORTS-1:0]     fmt_sew_o,
   output logic       [R_PORTS-1:0][1:0] fmt_byte_sel_o,
   // Toward the result stage, stage READ_LAT
   output issue_t     [W_PORTS-1:0]     issue_o,
   output store_ctl_t                   store_ctl_o
);

   ////////////////////////////////////////
   // Pipeline registers
   ////////////////////////////////////////

   // Index 0 is the stage one edge after issue
   issue_t     [READ_LAT-1:0][W_PORTS-1:0] issue_q;
   store_ctl_t [READ_LAT-1:0]              store_q;
   // Byte selects are only needed at stage 1
   logic       [R_PORTS-1:0][1:0]          bsel_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         issue_q <= '0;
         store_q <= '0;
         bsel_q  <= '0;
      end else begin
         issue_q[0] <= issue_i;
         store_q[0] <= store_ctl_i;
         bsel_q     <= byte_sel_i;
         // Shift older packets down the pipe
         for (int s = 1; s < READ_LAT; s++) begin
            issue_q[s] <= issue_q[s-1];
            store_q[s] <= store_q[s-1];
         end
      end
   end

   ////////////////////////////////////////
   // Stage 1 format controls
   ////////////////////////////////////////

   // Each slot owns a consecutive pair of read ports
   always_comb begin
      for (int p = 0; p < R_PORTS; p++) begin
         fmt_sew_o[p] = issue_q[0][p / (R_PORTS / W_PORTS)].read_sew;
      end
   end

   assign fmt_byte_sel_o = bsel_q;

   ////////////////////////////////////////
   // Result stage packet
   ////////////////////////////////////////

   // Lines up with the registered formatted words
   assign issue_o     = issue_q[READ_LAT-1];
   assign store_ctl_o = store_q[READ_LAT-1];

endmodule

//--- verilog/lane_pkg.sv
package lane_pkg;

   ////////////////////////////////////////
   // Lane sizes
   ////////////////////////////////////////

   // VRF read ports, two per issue slot
   localparam int R_PORTS    = 4;
   // VRF write ports, one per issue slot
   localparam int W_PORTS    = 2;
   localparam int VRF_DEPTH  = 64;
   localparam int VRF_AW     = 6;
   localparam int XLEN       = 32;
   localparam int ALU_CTRL_W = 6;
   // Edges from issue to operand valid
   localparam int READ_LAT   = 2;
   // Raw read port forwarded as slide data
   localparam int SLIDE_PORT = 1;

   ////////////////////////////////////////
   // Codes
   ////////////////////////////////////////

   // Element width, code 3 reads as a word
   typedef logic [1:0] sew_t;
   localparam sew_t SEW_8  = 2'd0;
   localparam sew_t SEW_16 = 2'd1;
   localparam sew_t SEW_32 = 2'd2;

   // VRF write data source
   typedef enum logic [1:0] {
      WSRC_ALU   = 2'd0,
      WSRC_LOAD  = 2'd1,
      WSRC_SLIDE = 2'd2,
      WSRC_ZERO  = 2'd3
   } wsrc_t;

   // Index of a read port
   typedef logic [1:0] rport_sel_t;

   ////////////////////////////////////////
   // Request and issue packets
   ////////////////////////////////////////

   // One per read port
   typedef struct packed {
      logic [VRF_AW-1:0] addr;
      logic [1:0]        byte_sel;
   } rd_req_t;

   // One per write port
   typedef struct packed {
      logic [VRF_AW-1:0] addr;
      logic [3:0]        bwen;
      wsrc_t             src;
   } wr_req_t;

   // One per issue slot
   typedef struct packed {
      logic [ALU_CTRL_W-1:0] alu_ctrl;
      logic                  reduction;
      sew_t                  read_sew;
      sew_t                  write_sew;
      rport_sel_t            op3_sel;
      logic                  read_valid;
      logic                  store_valid;
      logic                  index_valid;
   } issue_t;

   // Shared by both slots of an issue
   typedef struct packed {
      rport_sel_t store_sel;
      rport_sel_t index_sel;
   } store_ctl_t;

endpackage
